//--- kx7_if_top.f
verilog/kx7_pkg.sv
verilog/bus_ctrl.sv
verilog/cmd_seq.sv
verilog/rx_deser.sv
verilog/data_fifo.sv
verilog/kx7_if_top.sv
verif/kx7_if_top_asserts.sv
verif/kx7_if_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then decide on the simulation log
verilator --binary --timing --assert -Wno-fatal --top-module kx7_if_top_tb \
    -f kx7_if_top.f -o kx7_sim > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/kx7_sim > sim.log 2>&1
status=$?
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
[ "$status" -eq 0 ] && grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1

//--- verif/kx7_if_top_tb.sv
module kx7_if_top_tb
    import kx7_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum int {OP_WR, OP_RD, OP_FRAME, OP_ABORT, OP_CMD, OP_PINS} op_t;

    typedef struct {
        op_t       op;
        bus_addr_t addr;   // Bits sent before abort for OP_ABORT
        bus_data_t data;   // Payload for frames and length for OP_CMD
        bus_data_t exp;
        int        test;
    } row_t;

    logic       bus_clk = 1'b0;
    logic       rst_n;
    bus_addr_t  bus_add;
    logic       bus_wr;
    logic       bus_rd;
    bus_data_t  bus_data_in;
    bus_data_t  bus_data_out;
    logic       rx_data;
    logic       cmd_data;
    logic       cmd_ready;
    logic [8:1] led;

    row_t        rows[$];
    string       test_names[$];
    cmd_byte_t   cmd_model [CMD_MEM_DEPTH];  // Bytes the host wrote
    int unsigned lcg_state   = 34697;
    int          cycles      = 0;
    int          cycle_limit = 0;
    int          budget_sum  = 0;
    int          checks      = 0;
    int          errors      = 0;
    int          test_checks = 0;
    int          test_errors = 0;

    kx7_if_top i_kx7_if_top (
        .bus_clk(bus_clk), .rst_n(rst_n),
        .bus_add(bus_add), .bus_wr(bus_wr), .bus_rd(bus_rd),
        .bus_data_in(bus_data_in), .bus_data_out(bus_data_out),
        .rx_data(rx_data), .cmd_data(cmd_data), .cmd_ready(cmd_ready),
        .led(led)
    );

    always #50 bus_clk = !bus_clk;  // 100 ns period

    // Run limit
    always @(posedge bus_clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int row_budget(op_t op, bus_data_t data);
        case (op)
            OP_WR:    return 2;
            OP_RD:    return 3;
            OP_FRAME: return 26;   // Start bit plus 24 payload bits and one idle
            OP_ABORT: return 40;
            OP_CMD:   return 8 * int'(data[4:0]) + 3;
            default:  return 1;
        endcase
    endfunction

    function automatic void add_row(op_t op, bus_addr_t addr, bus_data_t data, bus_data_t exp);
        row_t r;
        r.op   = op;
        r.addr = addr;
        r.data = data;
        r.exp  = exp;
        r.test = test_names.size() - 1;
        rows.push_back(r);
        budget_sum += row_budget(op, data);
    endfunction

    function automatic void build_table();
        bus_data_t   word;
        logic [23:0] pl [FIFO_DEPTH+1];

        test_names.push_back("reset values and register access");
        add_row(OP_PINS, '0, '0, 32'h0000_0102);  // cmd_data 0 and cmd_ready 1 with led[2] only
        add_row(OP_RD, CMD_STATUS_ADDR, '0, 32'd1);
        add_row(OP_RD, RX_CTRL_ADDR, '0, '0);
        add_row(OP_RD, RX_STATUS_ADDR, '0, '0);
        add_row(OP_RD, FIFO_COUNT_ADDR, '0, '0);
        for (int i = 0; i < CMD_MEM_DEPTH; i++) begin
            word         = lcg_next();
            cmd_model[i] = word[7:0];                  // Only the low byte sticks
            add_row(OP_WR, CMD_MEM_BASE + bus_addr_t'(i), word, '0);
        end
        for (int i = 0; i < CMD_MEM_DEPTH; i++) begin
            add_row(OP_RD, CMD_MEM_BASE + bus_addr_t'(i), '0, {24'd0, cmd_model[i]});
        end
        word = lcg_next();
        add_row(OP_WR, CMD_LEN_ADDR, word, '0);
        add_row(OP_RD, CMD_LEN_ADDR, '0, {24'd0, word[7:0]});
        add_row(OP_WR, 32'h0000_0040, 32'hFFFF_FFFF, '0);  // Unmapped write is dropped
        add_row(OP_RD, 32'h0000_0013, '0, '0);
        add_row(OP_RD, 32'h0000_0040, '0, '0);
        add_row(OP_RD, 32'h7FFF_FFFF, '0, '0);

        test_names.push_back("command stream");
        add_row(OP_WR, CMD_LEN_ADDR, 32'd3, '0);
        add_row(OP_CMD, CMD_START_ADDR, 32'd3, '0);
        add_row(OP_RD, CMD_STATUS_ADDR, '0, 32'd1);
        add_row(OP_WR, CMD_LEN_ADDR, '0, '0);
        add_row(OP_WR, CMD_START_ADDR, '0, '0);     // Zero length keeps it ready
        add_row(OP_PINS, '0, '0, 32'h0000_0102);

        test_names.push_back("frame capture");
        add_row(OP_WR, RX_CTRL_ADDR, 32'd1, '0);
        for (int i = 0; i < 4; i++) begin
            pl[i] = 24'(lcg_next() >> 8);
            add_row(OP_FRAME, '0, {8'd0, pl[i]}, '0);
        end
        add_row(OP_RD, FIFO_COUNT_ADDR, '0, 32'd4);
        for (int i = 0; i < 4; i++) begin
            add_row(OP_RD, FIFO_DATA_BASE + bus_addr_t'(4 * i), '0, {RX_ID, pl[i]});
        end
        add_row(OP_RD, FIFO_COUNT_ADDR, '0, '0);

        test_names.push_back("enable gating and abort");
        add_row(OP_WR, RX_CTRL_ADDR, '0, '0);
        add_row(OP_FRAME, '0, 32'h00A5_5A5A, '0);
        add_row(OP_FRAME, '0, 32'h00FF_FFFF, '0);
        add_row(OP_RD, FIFO_COUNT_ADDR, '0, '0);
        add_row(OP_WR, RX_CTRL_ADDR, 32'd1, '0);
        add_row(OP_ABORT, 32'd10, 32'h00C3_C3C3, '0);
        add_row(OP_RD, FIFO_COUNT_ADDR, '0, '0);
        pl[0] = 24'(lcg_next() >> 8);
        add_row(OP_FRAME, '0, {8'd0, pl[0]}, '0);  // Receiver back in service
        add_row(OP_RD, FIFO_COUNT_ADDR, '0, 32'd1);
        add_row(OP_RD, FIFO_DATA_BASE, '0, {RX_ID, pl[0]});

        test_names.push_back("flags");
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            pl[i] = 24'(lcg_next() >> 8);
            add_row(OP_FRAME, '0, {8'd0, pl[i]}, '0);
        end
        add_row(OP_RD, FIFO_COUNT_ADDR, '0, 32'd16);
        add_row(OP_PINS, '0, '0, 32'h0000_013F);    // Full, near full, overflow
        add_row(OP_RD, RX_STATUS_ADDR, '0, 32'd3);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            add_row(OP_RD, FIFO_DATA_BASE, '0, {RX_ID, pl[i]});
        end
        add_row(OP_RD, FIFO_DATA_BASE, '0, '0);    // Empty pop
        add_row(OP_RD, RX_STATUS_ADDR, '0, 32'd7);
        add_row(OP_PINS, '0, '0, 32'h0000_0147);
        add_row(OP_WR, RX_RESET_ADDR, '0, '0);
        add_row(OP_RD, RX_STATUS_ADDR, '0, 32'd1);
        add_row(OP_PINS, '0, '0, 32'h0000_0103);
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus and serial drivers
    ////////////////////////////////////////////////////////////

    task automatic write_bus(bus_addr_t addr, bus_data_t data);
        @(posedge bus_clk);
        bus_add     <= addr;
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge bus_clk);
        bus_wr <= 1'b0;
    endtask

    task automatic read_bus(bus_addr_t addr, output bus_data_t data);
        @(posedge bus_clk);
        bus_add <= addr;
        bus_rd  <= 1'b1;
        @(posedge bus_clk);
        bus_rd <= 1'b0;
        @(negedge bus_clk);   // Registered word is settled here
        data = bus_data_out;
    endtask

    // Start bit, then nbits of the payload MSB first
    task automatic send_bits(bus_data_t payload, int nbits);
        @(posedge bus_clk);
        rx_data <= 1'b1;
        for (int i = 0; i < nbits; i++) begin
            @(posedge bus_clk);
            rx_data <= payload[23 - i];
        end
    endtask

    task automatic check_value(string what, bus_data_t got, bus_data_t exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("** Error at %0t: %s gave 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(int idx);
        $display("Test %0d %s: %0d checks, %0d errors", idx + 1, test_names[idx],
                 test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // Row execution
    ////////////////////////////////////////////////////////////

    task automatic apply_row(row_t r);
        bus_data_t got;
        int        nbits;
        logic      exp_bit;
        case (r.op)
            OP_WR: write_bus(r.addr, r.data);
            OP_RD: begin
                read_bus(r.addr, got);
                check_value($sformatf("read of 0x%08h", r.addr), got, r.exp);
            end
            OP_FRAME: begin
                send_bits(r.data, RX_FRAME_BITS);
                @(posedge bus_clk);
                rx_data <= 1'b0;  // Idle gap
            end
            OP_ABORT: begin
                send_bits(r.data, int'(r.addr));
                @(posedge bus_clk);
                rx_data <= 1'b0;
                write_bus(RX_CTRL_ADDR, '0);
                write_bus(RX_CTRL_ADDR, 32'd1);
            end
            OP_CMD: begin
                nbits = 8 * int'(r.data);
                write_bus(CMD_START_ADDR, '0);
                for (int k = 0; k < nbits; k++) begin
                    @(negedge bus_clk);
                    exp_bit = cmd_model[k / 8][7 - (k % 8)];  // Byte 0 first, MSB first
                    check_value($sformatf("stream bit %0d {led[8], cmd_ready, cmd_data}", k),
                                bus_data_t'({led[8], cmd_ready, cmd_data}),
                                bus_data_t'({1'b1, 1'b0, exp_bit}));
                    @(posedge bus_clk);
                    bus_add <= CMD_START_ADDR;
                    bus_wr  <= (k == 4);                     // Start again while busy
                end
                @(negedge bus_clk);
                check_value("stream end {led[8], cmd_ready, cmd_data}",
                            bus_data_t'({led[8], cmd_ready, cmd_data}), 32'd2);
            end
            OP_PINS: begin
                @(negedge bus_clk);
                check_value("pins {cmd_data, cmd_ready, led}",
                            bus_data_t'({cmd_data, cmd_ready, led}), r.exp);
            end
            default: ;
        endcase
    endtask

    initial begin
        int cur_test;
        rst_n       = 1'b0;
        bus_add     = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        bus_data_in = '0;
        rx_data     = 1'b0;
        build_table();
        cycle_limit = 2 * (budget_sum + 4);
        repeat (3) @(posedge bus_clk);
        rst_n <= 1'b1;
        cur_test = 0;
        foreach (rows[i]) begin
            if (rows[i].test != cur_test) begin
                report_test(cur_test);
                cur_test = rows[i].test;
            end
            apply_row(rows[i]);
        end
        report_test(cur_test);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verif/kx7_if_top_asserts.sv
module kx7_if_top_asserts
    import kx7_pkg::*;
(
    input logic       bus_clk,
    input logic       rst_n,
    input bus_addr_t  bus_add,
    input logic       bus_rd,
    input bus_data_t  bus_data_out,
    input logic       cmd_data,
    input logic       cmd_ready,
    input logic [8:1] led
);
    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////////////////////////
    // Port level properties
    ////////////////////////////////////////////////////////////

    // Command line rests low when idle
    a_cmd_idle_low: assert property (@(posedge bus_clk) disable iff (!rst_n)
        cmd_ready |-> !cmd_data)
        else $error("cmd_data high while cmd_ready is set");

    // Full FIFO is also near full and not empty
    a_full_levels: assert property (@(posedge bus_clk) disable iff (!rst_n)
        led[4] |-> (led[6] && led[5]))
        else $error("full LED without near-full and not-empty LEDs");

    // Occupancy read never beyond depth
    a_count_range: assert property (@(posedge bus_clk) disable iff (!rst_n)
        (bus_rd && (bus_add == FIFO_COUNT_ADDR)) |=>
            (bus_data_out <= bus_data_t'(FIFO_DEPTH)))
        else $error("FIFO count read above depth");

endmodule

bind kx7_if_top kx7_if_top_asserts i_kx7_if_top_asserts (
    .bus_clk(bus_clk), .rst_n(rst_n),
    .bus_add(bus_add), .bus_rd(bus_rd), .bus_data_out(bus_data_out),
    .cmd_data(cmd_data), .cmd_ready(cmd_ready), .led(led)
);

//--- verilog/kx7_if_top.sv
module kx7_if_top
    import kx7_pkg::*;
(
    input  logic       bus_clk,
    input  logic       rst_n,

    // Host bus
    input  bus_addr_t  bus_add,
    input  logic       bus_wr,
    input  logic       bus_rd,
    input  bus_data_t  bus_data_in,
    output bus_data_t  bus_data_out,

    // Front end serial lines
    input  logic       rx_data,
    output logic       cmd_data,
    output logic       cmd_ready,

    output logic [8:1] led
);

    logic                  cmd_mem_we;
    logic [CMD_ADDR_W-1:0] cmd_mem_addr;
    cmd_byte_t             cmd_mem_wdata;
    cmd_byte_t             cmd_mem_rdata;
    logic                  cmd_start;
    cmd_len_t              cmd_len;

    logic                  rx_enable;
    logic                  push;
    bus_data_t             push_data;

    logic                  pop;
    bus_data_t             pop_data;
    fifo_cnt_t             count;
    logic                  full, near_full, not_empty;
    logic                  overflow, read_error, flag_clear;

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    bus_ctrl i_bus_ctrl (
        .bus_clk(bus_clk), .rst_n(rst_n),
        .bus_add(bus_add), .bus_wr(bus_wr), .bus_rd(bus_rd),
        .bus_data_in(bus_data_in), .bus_data_out(bus_data_out),
        .cmd_mem_we(cmd_mem_we), .cmd_mem_addr(cmd_mem_addr),
        .cmd_mem_wdata(cmd_mem_wdata), .cmd_mem_rdata(cmd_mem_rdata),
        .cmd_start(cmd_start), .cmd_len(cmd_len), .cmd_ready(cmd_ready),
        .rx_enable(rx_enable),
        .pop(pop), .pop_data(pop_data), .count(count),
        .overflow(overflow), .read_error(read_error), .flag_clear(flag_clear)
    );

    cmd_seq i_cmd_seq (
        .bus_clk(bus_clk), .rst_n(rst_n),
        .cmd_mem_we(cmd_mem_we), .cmd_mem_addr(cmd_mem_addr),
        .cmd_mem_wdata(cmd_mem_wdata), .cmd_mem_rdata(cmd_mem_rdata),
        .cmd_start(cmd_start), .cmd_len(cmd_len), .cmd_ready(cmd_ready),
        .cmd_data(cmd_data)
    );

    rx_deser i_rx_deser (
        .bus_clk(bus_clk), .rst_n(rst_n),
        .rx_enable(rx_enable), .rx_data(rx_data),
        .push(push), .push_data(push_data)
    );

    data_fifo i_data_fifo (
        .bus_clk(bus_clk), .rst_n(rst_n),
        .push(push), .push_data(push_data),
        .pop(pop), .pop_data(pop_data),
        .count(count), .full(full), .near_full(near_full), .not_empty(not_empty),
        .overflow(overflow), .read_error(read_error), .flag_clear(flag_clear)
    );

    // Status LEDs
    assign led[1] = rx_enable;
    assign led[2] = cmd_ready;
    assign led[3] = overflow;
    assign led[4] = full;
    assign led[5] = not_empty;
    assign led[6] = near_full;
    assign led[7] = read_error;
    assign led[8] = !cmd_ready;   // Stream in progress

endmodule

//--- verilog/data_fifo.sv
module data_fifo
    import kx7_pkg::*;
(
    input  logic      bus_clk,
    input  logic      rst_n,

    // Write side, no back-pressure
    input  logic      push,
    input  bus_data_t push_data,

    // Read side
    input  logic      pop,
    output bus_data_t pop_data,

    // Status
    output fifo_cnt_t count,
    output logic      full,
    output logic      near_full,
    output logic      not_empty,
    output logic      overflow,    // Sticky
    output logic      read_error,  // Sticky
    input  logic      flag_clear
);

    bus_data_t             mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push && !full;       // Word dropped when full
    assign do_pop  = pop && not_empty;

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge bus_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Empty reads give zero
    assign pop_data = not_empty ? mem[rd_ptr] : '0;

    ////////////////////////////////////////////////////////////
    // Pointers, count and flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow   <= 1'b0;
            read_error <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 5'd1;
                2'b01:   count <= count - 5'd1;
                default: count <= count;    // Both or neither
            endcase

            // Clear first so a same-cycle event still sets the flag
            if (flag_clear) begin
                overflow   <= 1'b0;
                read_error <= 1'b0;
            end
            if (push && full) begin
                overflow <= 1'b1;
            end
            if (pop && !not_empty) begin
                read_error <= 1'b1;
            end
        end
    end

    assign full      = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign near_full = (count >= fifo_cnt_t'(FIFO_NEAR_FULL_LVL));
    assign not_empty = (count != '0);

endmodule

//--- verilog/rx_deser.sv
module rx_deser
    import kx7_pkg::*;
(
    input  logic      bus_clk,
    input  logic      rst_n,
    input  logic      rx_enable,
    input  logic      rx_data,    // Serial level from the front end
    output logic      push,
    output bus_data_t push_data
);

    typedef enum logic {
        HUNT,
        CAPTURE
    } rx_state_t;

    rx_state_t                state;
    logic [4:0]               bit_cnt;   // Payload bits taken so far
    logic [RX_FRAME_BITS-1:0] shift_q;   // Payload with the MSB arriving first

    ////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            state   <= HUNT;
            bit_cnt <= '0;
            push    <= 1'b0;
        end else begin
            push <= 1'b0;  // Single cycle strobe
            if (!rx_enable) begin
                // Partial frame is thrown away
                state   <= HUNT;
                bit_cnt <= '0;
            end else begin
                case (state)
                    HUNT: begin
                        if (rx_data) begin   // Start bit
                            state   <= CAPTURE;
                            bit_cnt <= '0;
                        end
                    end
                    CAPTURE: begin
                        bit_cnt <= bit_cnt + 5'd1;
                        if (bit_cnt == 5'(RX_FRAME_BITS - 1)) begin
                            state <= HUNT;
                            push  <= 1'b1;   // Word complete
                        end
                    end
                    default: state <= HUNT;
                endcase
            end
        end
    end

    // Payload shifter
    always_ff @(posedge bus_clk) begin
        if (rx_enable && (state == CAPTURE)) begin
            shift_q <= {shift_q[RX_FRAME_BITS-2:0], rx_data};
        end
    end

    // Shifter holds still in hunt, so the word is stable during push
    assign push_data = {RX_ID, shift_q};

endmodule

//--- verilog/cmd_seq.sv
module cmd_seq
    import kx7_pkg::*;
(
    input  logic                  bus_clk,
    input  logic                  rst_n,

    // Byte memory port from the control module
    input  logic                  cmd_mem_we,
    input  logic [CMD_ADDR_W-1:0] cmd_mem_addr,
    input  cmd_byte_t             cmd_mem_wdata,
    output cmd_byte_t             cmd_mem_rdata,

    // Sequence control
    input  logic                  cmd_start,
    input  cmd_len_t              cmd_len,
    output logic                  cmd_ready,

    // Serial command stream
    output logic                  cmd_data
);

    typedef enum logic {
        IDLE,
        SHIFT
    } cmd_state_t;

    cmd_state_t state;

    cmd_byte_t  mem [CMD_MEM_DEPTH];
    cmd_len_t   len_q;     // Length latched at start
    logic [7:0] bit_cnt;   // Next bit index, byte in 6:3, bit in 2:0
    logic [7:0] bit_end;   // Total bits in this sequence
    cmd_byte_t  cur_byte;
    logic       cur_bit;

    ////////////////////////////////////////////////////////////
    // Command byte memory
    ////////////////////////////////////////////////////////////

    always_ff @(posedge bus_clk) begin
        if (cmd_mem_we) begin
            mem[cmd_mem_addr] <= cmd_mem_wdata;
        end
    end

    assign cmd_mem_rdata = mem[cmd_mem_addr];  // Async read for the host

    ////////////////////////////////////////////////////////////
    // Serializer
    ////////////////////////////////////////////////////////////

    assign bit_end  = {len_q, 3'b000};               // 8 bits per byte
    assign cur_byte = mem[bit_cnt[6:3]];
    assign cur_bit  = cur_byte[3'd7 - bit_cnt[2:0]]; // MSB first

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            len_q    <= '0;
            bit_cnt  <= '0;
            cmd_data <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    cmd_data <= 1'b0;
                    // Zero length leaves the sequencer idle
                    if (cmd_start && (cmd_len != '0)) begin
                        state    <= SHIFT;
                        len_q    <= cmd_len;
                        cmd_data <= mem[0][7];       // First bit goes out right away
                        bit_cnt  <= 8'd1;
                    end
                end
                SHIFT: begin
                    // Starts while busy are dropped here
                    if (bit_cnt == bit_end) begin
                        state    <= IDLE;
                        cmd_data <= 1'b0;
                        bit_cnt  <= '0;
                    end else begin
                        cmd_data <= cur_bit;
                        bit_cnt  <= bit_cnt + 8'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign cmd_ready = (state == IDLE);

endmodule

//--- verilog/bus_ctrl.sv
module bus_ctrl
    import kx7_pkg::*;
(
    input  logic                  bus_clk,
    input  logic                  rst_n,

    // Host bus
    input  bus_addr_t             bus_add,
    input  logic                  bus_wr,
    input  logic                  bus_rd,
    input  bus_data_t             bus_data_in,
    output bus_data_t             bus_data_out,

    // Command sequencer
    output logic                  cmd_mem_we,
    output logic [CMD_ADDR_W-1:0] cmd_mem_addr,
    output cmd_byte_t             cmd_mem_wdata,
    input  cmd_byte_t             cmd_mem_rdata,
    output logic                  cmd_start,
    output cmd_len_t              cmd_len,
    input  logic                  cmd_ready,

    // Receiver
    output logic                  rx_enable,

    // Output FIFO
    output logic                  pop,
    input  bus_data_t             pop_data,
    input  fifo_cnt_t             count,
    input  logic                  overflow,
    input  logic                  read_error,
    output logic                  flag_clear
);

    logic      byte_access;  // Below the data window
    logic      cmd_mem_sel;  // Hits one of the command bytes
    cmd_byte_t len_reg;      // Full byte kept for readback
    bus_data_t rd_word;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    assign byte_access = (bus_add < FIFO_DATA_BASE);
    assign cmd_mem_sel = (bus_add[31:CMD_ADDR_W] == CMD_MEM_BASE[31:CMD_ADDR_W]);

    // Command memory port, same address for read and write
    assign cmd_mem_addr  = bus_add[CMD_ADDR_W-1:0];
    assign cmd_mem_wdata = bus_data_in[7:0];          // Byte registers keep 7:0
    assign cmd_mem_we    = bus_wr && cmd_mem_sel;

    // Strobes, one cycle wide like bus_wr and bus_rd
    assign cmd_start  = bus_wr && (bus_add == CMD_START_ADDR);
    assign flag_clear = bus_wr && (bus_add == RX_RESET_ADDR);
    assign pop        = bus_rd && !byte_access;       // Data window read

    // Lengths above the memory size clamp to a full sweep
    assign cmd_len = (len_reg > CMD_MEM_DEPTH) ? cmd_len_t'(CMD_MEM_DEPTH)
                                               : cmd_len_t'(len_reg);

    ////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd_word = '0;  // Unmapped reads give zero
        if (!byte_access) begin
            rd_word = pop_data;                       // Already zero when empty
        end else if (cmd_mem_sel) begin
            rd_word = bus_data_t'(cmd_mem_rdata);
        end else begin
            case (bus_add)
                CMD_LEN_ADDR:    rd_word = bus_data_t'(len_reg);
                CMD_STATUS_ADDR: rd_word = bus_data_t'(cmd_ready);
                RX_CTRL_ADDR:    rd_word = bus_data_t'(rx_enable);
                // Bit 2 carries the FIFO read error next to overflow
                RX_STATUS_ADDR:  rd_word = bus_data_t'({read_error, overflow, rx_enable});
                FIFO_COUNT_ADDR: rd_word = bus_data_t'(count);
                default:         rd_word = '0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge bus_clk) begin
        if (!rst_n) begin
            len_reg      <= '0;
            rx_enable    <= 1'b0;
            bus_data_out <= '0;
        end else begin
            if (bus_wr && (bus_add == CMD_LEN_ADDR)) begin
                len_reg <= bus_data_in[7:0];
            end
            if (bus_wr && (bus_add == RX_CTRL_ADDR)) begin
                rx_enable <= bus_data_in[0];
            end
            // Held until the next read strobe
            if (bus_rd) begin
                bus_data_out <= rd_word;
            end
        end
    end

endmodule

//--- verilog/kx7_pkg.sv
package kx7_pkg;

    ////////////////////////////////////////////////////////////
    // Widths that carry a meaning
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] bus_addr_t;   // Host bus address
    typedef logic [31:0] bus_data_t;   // Host bus data word
    typedef logic [7:0]  cmd_byte_t;   // One command byte
    typedef logic [4:0]  cmd_len_t;    // Command length, 0 to 16 bytes
    typedef logic [4:0]  fifo_cnt_t;   // FIFO occupancy, 0 to 16 words

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    localparam int CMD_MEM_DEPTH = 16;
    localparam int CMD_ADDR_W    = $clog2(CMD_MEM_DEPTH);  // Byte index into command memory

    localparam int FIFO_DEPTH         = 16;
    localparam int FIFO_PTR_W         = $clog2(FIFO_DEPTH);
    localparam int FIFO_NEAR_FULL_LVL = 12;

    localparam int          RX_FRAME_BITS = 24;     // Payload bits per frame
    localparam logic [7:0]  RX_ID         = 8'h04;  // Goes into word bits 31:24

    ////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////

    // Byte register space, below the data window
    localparam bus_addr_t CMD_MEM_BASE    = 32'h0000_0000;  // 0x00..0x0F command bytes
    localparam bus_addr_t CMD_START_ADDR  = 32'h0000_0010;  // Write only
    localparam bus_addr_t CMD_LEN_ADDR    = 32'h0000_0011;
    localparam bus_addr_t CMD_STATUS_ADDR = 32'h0000_0012;  // Bit 0 cmd_ready

    localparam bus_addr_t RX_CTRL_ADDR    = 32'h0000_0020;  // Bit 0 receive enable
    localparam bus_addr_t RX_STATUS_ADDR  = 32'h0000_0021;
    localparam bus_addr_t RX_RESET_ADDR   = 32'h0000_0022;  // Write only, clears sticky flags

    localparam bus_addr_t FIFO_COUNT_ADDR = 32'h0000_0030;

    // Full word reads from here up, each read pops one word
    localparam bus_addr_t FIFO_DATA_BASE  = 32'h8000_0000;

endpackage
